// ==== aesPkg.sv ====
package aesPkg;

    // ========================================================================
    // Block geometry
    // ========================================================================

    localparam int AesWidth  = 128;
    localparam int AesRounds = 10;

    typedef logic [AesWidth-1:0] aesBlock_t;

    // The cipher state as one flat block or as four columns of four bytes.
    // col[3] is column 0 and within a column byte [3] is row 0, so the
    // flat view keeps the FIPS-197 byte order with byte 0 most significant
    typedef union packed {
        aesBlock_t            flat;
        logic [3:0][3:0][7:0] col;
    } aesState_t;

    // Entry 0 of the round constants belongs to round 1
    localparam logic [9:0][7:0] rconTable = {
        8'h36, 8'h1b, 8'h80, 8'h40, 8'h20,
        8'h10, 8'h08, 8'h04, 8'h02, 8'h01
    };

    // ========================================================================
    // GF(2^8) arithmetic
    // ========================================================================

    // Multiply by x modulo the AES polynomial x^8 + x^4 + x^3 + x + 1
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] term;
        acc  = 8'h00;
        term = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                acc = acc ^ term;
            end
            term = xtime(term);
        end
        return acc;
    endfunction

    // S-box built from the multiplicative inverse followed by the affine map.
    // The inverse is b^254, collected as b^2 * b^4 * ... * b^128, which maps 0 to 0
    function automatic logic [7:0] subByte(input logic [7:0] b);
        logic [7:0] power;
        logic [7:0] inv;
        logic [7:0] res;
        power = b;
        inv   = 8'h01;
        for (int i = 1; i < 8; i++) begin
            power = gfMul(power, power);
            inv   = gfMul(inv, power);
        end
        for (int i = 0; i < 8; i++) begin
            res[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8]
                     ^ inv[(i + 6) % 8] ^ inv[(i + 7) % 8];
        end
        return res ^ 8'h63;
    endfunction

    // ========================================================================
    // Round steps
    // ========================================================================

    // One column times the fixed matrix {02 03 01 01} with row 0 in the top byte
    function automatic logic [31:0] mixColumn(input logic [31:0] column);
        logic [7:0] a0;
        logic [7:0] a1;
        logic [7:0] a2;
        logic [7:0] a3;
        a0 = column[31:24];
        a1 = column[23:16];
        a2 = column[15:8];
        a3 = column[7:0];
        return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
                a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
                a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
                xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
    endfunction

    function automatic logic [31:0] subWord(input logic [31:0] word);
        return {subByte(word[31:24]), subByte(word[23:16]),
                subByte(word[15:8]), subByte(word[7:0])};
    endfunction

    // One step of the AES-128 key expansion with word 0 in the top 32 bits
    function automatic aesBlock_t nextRoundKey(input aesBlock_t prevKey,
                                               input logic [7:0] rcon);
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] w2;
        logic [31:0] w3;
        logic [31:0] temp;
        temp = subWord({prevKey[23:0], prevKey[31:24]}) ^ {rcon, 24'h000000};
        w0   = prevKey[127:96] ^ temp;
        w1   = prevKey[95:64] ^ w0;
        w2   = prevKey[63:32] ^ w1;
        w3   = prevKey[31:0] ^ w2;
        return {w0, w1, w2, w3};
    endfunction

endpackage

// ==== prngPkg.sv ====
package prngPkg;

    // The output word width of the generator must divide the AES block width
    localparam int RandWidth = 32;

    // Ciphertext blocks held between the encryptor and the output funnel
    localparam int BufferDepth = 2;

    // Output words carved from one ciphertext block
    localparam int ChunksPerBlock = aesPkg::AesWidth / RandWidth;

    // Fixed key of the counter-mode generator
    localparam aesPkg::aesBlock_t DefaultKey = 128'hd840_e1a8_dcca_e7ec_d91f_6148_7af2_cb73;

endpackage

// ==== aesCore.sv ====
`timescale 1ns/1ps

module aesCore
    import aesPkg::*;
#(
    parameter aesBlock_t Key = '0
) (
    input  logic      Clock,
    input  logic      rstN,
    input  aesBlock_t seed,
    input  logic      seedValid,
    output logic      coreReady,
    output aesBlock_t coreOut,
    output logic      coreOutValid
);

    localparam logic [3:0] LastRound = 4'(AesRounds);
    localparam logic [3:0] DoneStep  = 4'(AesRounds + 1);

    aesState_t  state;
    aesState_t  shifted;
    aesState_t  mixed;
    aesState_t  roundOut;
    aesBlock_t  roundKey;
    aesBlock_t  nextKey;
    logic [3:0] round;
    logic [3:0] rconIdx;
    logic       busy;
    logic       accept;

    assign coreReady = !busy;
    assign accept    = seedValid && coreReady;

    // The state holds the ciphertext until the next seed is accepted
    assign coreOut = state.flat;

    // ========================================================================
    // Round datapath
    // ========================================================================

    // The round key is expanded for the round applied in this cycle
    assign rconIdx = (round >= 4'd1 && round <= LastRound) ? round - 4'd1 : 4'd0;
    assign nextKey = nextRoundKey(roundKey, rconTable[rconIdx]);

    always_comb begin
        // SubBytes and ShiftRows together, row r rotates left by r columns
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                shifted.col[3-c][3-r] = subByte(state.col[3-((c + r) % 4)][3-r]);
            end
        end
        for (int c = 0; c < 4; c++) begin
            mixed.col[3-c] = mixColumn(shifted.col[3-c]);
        end
        // The final round has no MixColumns
        if (round == LastRound) begin
            roundOut.flat = shifted.flat ^ nextKey;
        end else begin
            roundOut.flat = mixed.flat ^ nextKey;
        end
    end

    always_ff @(posedge Clock) begin
        if (accept) begin
            // Initial AddRoundKey happens on the load itself
            state.flat <= seed ^ Key;
            roundKey   <= Key;
        end else if (busy && round <= LastRound) begin
            state    <= roundOut;
            roundKey <= nextKey;
        end
    end

    // ========================================================================
    // Round sequencing
    // ========================================================================

    // Rounds 1 to 10 run on the ten edges after the accept. The step after
    // round 10 releases the result strobe and frees the core
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            busy         <= 1'b0;
            round        <= 4'd0;
            coreOutValid <= 1'b0;
        end else begin
            coreOutValid <= 1'b0;
            if (accept) begin
                busy  <= 1'b1;
                round <= 4'd1;
            end else if (busy) begin
                if (round == DoneStep) begin
                    busy         <= 1'b0;
                    round        <= 4'd0;
                    coreOutValid <= 1'b1;
                end else begin
                    round <= round + 4'd1;
                end
            end
        end
    end

endmodule

// ==== blockBuffer.sv ====
`timescale 1ns/1ps

module blockBuffer
    import aesPkg::*;
#(
    parameter int Depth = 2
) (
    input  logic      Clock,
    input  logic      rstN,
    input  aesBlock_t inData,
    input  logic      inValid,
    output logic      inReady,
    output aesBlock_t outData,
    output logic      outValid,
    input  logic      outReady
);

    localparam int PtrWidth   = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CountWidth = $clog2(Depth + 1);
    localparam logic [PtrWidth-1:0] LastIdx = PtrWidth'(Depth - 1);

    aesBlock_t             mem [Depth];
    logic [PtrWidth-1:0]   wrPtr;
    logic [PtrWidth-1:0]   rdPtr;
    logic [CountWidth-1:0] count;
    logic                  wrEn;
    logic                  rdEn;

    assign inReady  = count < CountWidth'(Depth);
    assign outValid = count != '0;
    assign outData  = mem[rdPtr];

    assign wrEn = inValid && inReady;
    assign rdEn = outValid && outReady;

    always_ff @(posedge Clock) begin
        if (wrEn) begin
            mem[wrPtr] <= inData;
        end
    end

    // Pointers wrap at Depth, which need not be a power of two
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (wrEn) begin
                wrPtr <= (wrPtr == LastIdx) ? '0 : wrPtr + 1'b1;
            end
            if (rdEn) begin
                rdPtr <= (rdPtr == LastIdx) ? '0 : rdPtr + 1'b1;
            end
            if (wrEn && !rdEn) begin
                count <= count + 1'b1;
            end else if (rdEn && !wrEn) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== widthFunnel.sv ====
`timescale 1ns/1ps

module widthFunnel
    import aesPkg::*;
#(
    parameter int OutWidth = 32
) (
    input  logic                Clock,
    input  logic                rstN,
    input  aesBlock_t           inData,
    input  logic                inValid,
    output logic                inReady,
    output logic [OutWidth-1:0] outData,
    output logic                outValid,
    input  logic                outReady
);

    localparam int Chunks   = AesWidth / OutWidth;
    localparam int IdxWidth = (Chunks > 1) ? $clog2(Chunks) : 1;
    localparam logic [IdxWidth-1:0] LastChunk = IdxWidth'(Chunks - 1);

    aesBlock_t           shiftReg;
    logic [IdxWidth-1:0] chunkIdx;
    logic                full;
    logic                outFire;
    logic                lastChunk;
    logic                load;

    // The current chunk always sits in the low bits of the block register
    assign outData  = shiftReg[OutWidth-1:0];
    assign outValid = full;

    assign outFire   = full && outReady;
    assign lastChunk = chunkIdx == LastChunk;
    assign inReady   = !full || (outFire && lastChunk);
    assign load      = inValid && inReady;

    always_ff @(posedge Clock) begin
        if (load) begin
            shiftReg <= inData;
        end else if (outFire) begin
            shiftReg <= shiftReg >> OutWidth;
        end
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            full     <= 1'b0;
            chunkIdx <= '0;
        end else if (load) begin
            full     <= 1'b1;
            chunkIdx <= '0;
        end else if (outFire) begin
            // Last chunk gone and nothing new arriving, so the funnel drains
            if (lastChunk) begin
                full <= 1'b0;
            end else begin
                chunkIdx <= chunkIdx + 1'b1;
            end
        end
    end

endmodule

// ==== prng.sv ====
`timescale 1ns/1ps

module prng
    import aesPkg::*;
    import prngPkg::*;
#(
    parameter int        RandWidth   = prngPkg::RandWidth,
    parameter aesBlock_t Key         = DefaultKey,
    parameter int        BufferDepth = prngPkg::BufferDepth
) (
    input  logic                 Clock,
    input  logic                 rstN,
    input  logic                 RandOutReady,
    output logic                 RandOutValid,
    output logic [RandWidth-1:0] RandOut
);

    aesBlock_t seedCount;
    logic      seedValid;
    logic      coreReady;
    aesBlock_t coreOut;
    logic      coreOutValid;
    logic      bufferReady;
    aesBlock_t bufferOut;
    logic      bufferValid;
    logic      funnelReady;

    // ========================================================================
    // Seed issue
    // ========================================================================

    // A block may only start when nothing is in flight and a buffer slot is
    // free, so the core strobe can never hit a full buffer
    assign seedValid = bufferReady && coreReady && !coreOutValid;

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            seedCount <= '0;
        end else if (seedValid && coreReady) begin
            seedCount <= seedCount + 1'b1;
        end
    end

    aesCore #(
        .Key(Key)
    ) core (
        .Clock(Clock),
        .rstN(rstN),
        .seed(seedCount),
        .seedValid(seedValid),
        .coreReady(coreReady),
        .coreOut(coreOut),
        .coreOutValid(coreOutValid)
    );

    blockBuffer #(
        .Depth(BufferDepth)
    ) outBuffer (
        .Clock(Clock),
        .rstN(rstN),
        .inData(coreOut),
        .inValid(coreOutValid),
        .inReady(bufferReady),
        .outData(bufferOut),
        .outValid(bufferValid),
        .outReady(funnelReady)
    );

    widthFunnel #(
        .OutWidth(RandWidth)
    ) outFunnel (
        .Clock(Clock),
        .rstN(rstN),
        .inData(bufferOut),
        .inValid(bufferValid),
        .inReady(funnelReady),
        .outData(RandOut),
        .outValid(RandOutValid),
        .outReady(RandOutReady)
    );

endmodule

// ==== tbPrng.sv ====
`timescale 1ns/1ps

module tbPrng
    import aesPkg::*;
    import prngPkg::*;
();

    localparam int ClockPeriod    = 10;
    localparam int NumCases       = 12;
    localparam int StallCycles    = 100;
    localparam int WatchdogCycles = NumCases * ChunksPerBlock * 30 + 200;

    // Row layout of the cases file
    localparam int KeyIdx          = 0;
    localparam int FipsKeyIdx      = 1;
    localparam int FipsPlainIdx    = 2;
    localparam int FipsCipherIdx   = 3;
    localparam int FirstCounterIdx = 4;

    logic                 Clock;
    logic                 rstN;
    logic                 RandOutReady;
    logic                 RandOutValid;
    logic [RandWidth-1:0] RandOut;

    aesBlock_t            caseMem [FirstCounterIdx + NumCases];
    aesBlock_t            expBlocks [$];
    logic [RandWidth-1:0] expWords [$];
    logic [7:0]           sboxTable [256];

    int                   errorCount;
    int                   wordsChecked;
    int                   blocksChecked;
    int                   wordIdx;
    int                   seedVar;
    logic                 holding;
    logic [RandWidth-1:0] heldWord;
    aesBlock_t            assembled;

    prng UUT (
        .Clock(Clock),
        .rstN(rstN),
        .RandOutReady(RandOutReady),
        .RandOutValid(RandOutValid),
        .RandOut(RandOut)
    );

    initial begin
        Clock = 1'b0;
        forever #(ClockPeriod / 2) Clock = ~Clock;
    end

    // ========================================================================
    // Reference AES-128 on a byte array state in column order
    // ========================================================================

    function automatic logic [7:0] gfProduct(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] x;
        logic [7:0] y;
        logic [7:0] p;
        x = a;
        y = b;
        p = 8'h00;
        while (y != 8'h00) begin
            if (y[0]) begin
                p = p ^ x;
            end
            x = x[7] ? ((x << 1) ^ 8'h1b) : (x << 1);
            y = y >> 1;
        end
        return p;
    endfunction

    function automatic logic [7:0] rotate8(input logic [7:0] v, input int n);
        return (v << n) | (v >> (8 - n));
    endfunction

    // The inverse is found by search and the affine map is written with rotations
    task automatic buildSbox();
        logic [7:0] inv;
        for (int x = 0; x < 256; x++) begin
            inv = 8'h00;
            for (int y = 1; y < 256; y++) begin
                if (gfProduct(8'(x), 8'(y)) == 8'h01) begin
                    inv = 8'(y);
                end
            end
            sboxTable[x] = inv ^ rotate8(inv, 1) ^ rotate8(inv, 2) ^ rotate8(inv, 3)
                           ^ rotate8(inv, 4) ^ 8'h63;
        end
    endtask

    function automatic aesBlock_t encryptBlock(input aesBlock_t key, input aesBlock_t plain);
        logic [7:0]  st [16];
        logic [7:0]  tmp [16];
        logic [31:0] w [44];
        logic [31:0] t;
        logic [7:0]  rc;
        logic [7:0]  a0;
        logic [7:0]  a1;
        logic [7:0]  a2;
        logic [7:0]  a3;
        aesState_t   res;
        rc = 8'h01;
        for (int i = 0; i < 4; i++) begin
            w[i] = key[127 - 32 * i -: 32];
        end
        for (int i = 4; i < 44; i++) begin
            t = w[i - 1];
            if (i % 4 == 0) begin
                t = {sboxTable[t[23:16]], sboxTable[t[15:8]], sboxTable[t[7:0]],
                     sboxTable[t[31:24]]} ^ {rc, 24'h000000};
                rc = gfProduct(rc, 8'h02);
            end
            w[i] = w[i - 4] ^ t;
        end
        for (int i = 0; i < 16; i++) begin
            st[i] = plain[127 - 8 * i -: 8] ^ w[i / 4][31 - 8 * (i % 4) -: 8];
        end
        for (int rnd = 1; rnd <= 10; rnd++) begin
            for (int c = 0; c < 4; c++) begin
                for (int r = 0; r < 4; r++) begin
                    tmp[4 * c + r] = sboxTable[st[4 * ((c + r) % 4) + r]];
                end
            end
            for (int c = 0; c < 4; c++) begin
                a0 = tmp[4 * c];
                a1 = tmp[4 * c + 1];
                a2 = tmp[4 * c + 2];
                a3 = tmp[4 * c + 3];
                if (rnd < 10) begin
                    st[4 * c]     = gfProduct(a0, 8'h02) ^ gfProduct(a1, 8'h03) ^ a2 ^ a3;
                    st[4 * c + 1] = a0 ^ gfProduct(a1, 8'h02) ^ gfProduct(a2, 8'h03) ^ a3;
                    st[4 * c + 2] = a0 ^ a1 ^ gfProduct(a2, 8'h02) ^ gfProduct(a3, 8'h03);
                    st[4 * c + 3] = gfProduct(a0, 8'h03) ^ a1 ^ a2 ^ gfProduct(a3, 8'h02);
                end else begin
                    st[4 * c]     = a0;
                    st[4 * c + 1] = a1;
                    st[4 * c + 2] = a2;
                    st[4 * c + 3] = a3;
                end
                for (int r = 0; r < 4; r++) begin
                    st[4 * c + r] = st[4 * c + r] ^ w[4 * rnd + c][31 - 8 * r -: 8];
                end
            end
        end
        res.flat = '0;
        for (int i = 0; i < 16; i++) begin
            res.flat[127 - 8 * i -: 8] = st[i];
        end
        return res.flat;
    endfunction

    // ========================================================================
    // Compare tasks
    // ========================================================================

    task automatic checkWord(input logic [RandWidth-1:0] actual,
                             input logic [RandWidth-1:0] expected, input int index);
        wordsChecked++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAIL @%0t: word %0d is %h, expected %h", $time, index, actual, expected);
        end
    endtask

    task automatic checkBlock(input aesBlock_t actual, input aesBlock_t expected,
                              input string what);
        blocksChecked++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAIL @%0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic checkFlag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            errorCount++;
            $display("FAIL @%0t: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    // ========================================================================
    // Stimulus
    // ========================================================================

    // Holds reset over three rising edges and samples RandOutValid mid-cycle
    task automatic applyReset();
        rstN         = 1'b0;
        RandOutReady = 1'b0;
        for (int i = 0; i < 3; i++) begin
            @(posedge Clock);
            if (i < 2) begin
                @(negedge Clock);
                checkFlag(RandOutValid, 1'b0, "RandOutValid during reset");
            end
        end
        #1;
        rstN = 1'b1;
        @(negedge Clock);
        checkFlag(RandOutValid, 1'b0, "RandOutValid after reset");
        wordIdx   = 0;
        holding   = 1'b0;
        assembled = '0;
    endtask

    // One clock cycle. The mid-cycle sample decides the transfer at the next edge
    task automatic stepCycle(input logic readyNext);
        @(posedge Clock);
        #1;
        RandOutReady = readyNext;
        @(negedge Clock);
        if (holding) begin
            checkFlag(RandOutValid, 1'b1, "RandOutValid while stalled");
            checkWord(RandOut, heldWord, wordIdx);
        end
        if (RandOutValid && RandOutReady) begin
            checkWord(RandOut, expWords[wordIdx], wordIdx);
            assembled = {RandOut, assembled[AesWidth-1:RandWidth]};
            if (wordIdx % ChunksPerBlock == ChunksPerBlock - 1) begin
                checkBlock(assembled, expBlocks[wordIdx / ChunksPerBlock],
                           $sformatf("block %0d", wordIdx / ChunksPerBlock));
            end
            wordIdx++;
        end
        holding  = RandOutValid && !RandOutReady;
        heldWord = RandOut;
    endtask

    initial begin
        aesBlock_t blk;
        int        rnd;
        rstN          = 1'b0;
        RandOutReady  = 1'b0;
        errorCount    = 0;
        wordsChecked  = 0;
        blocksChecked = 0;
        seedVar       = 11;
        $readmemh("prngCases.txt", caseMem);
        buildSbox();

        // The reference model must reproduce the known vector first
        checkBlock(encryptBlock(caseMem[FipsKeyIdx], caseMem[FipsPlainIdx]),
                   caseMem[FipsCipherIdx], "reference model check vector");
        checkBlock(caseMem[KeyIdx], DefaultKey, "key in cases file");
        for (int k = 0; k < NumCases; k++) begin
            blk = encryptBlock(caseMem[KeyIdx], caseMem[FirstCounterIdx + k]);
            expBlocks.push_back(blk);
            for (int j = 0; j < ChunksPerBlock; j++) begin
                expWords.push_back(blk[j * RandWidth +: RandWidth]);
            end
        end

        applyReset();
        while (wordIdx < 4 * ChunksPerBlock) begin
            stepCycle(1'b1);
        end
        while (wordIdx < 8 * ChunksPerBlock) begin
            rnd = $random(seedVar);
            stepCycle(rnd[0]);
        end

        // Long stall once a word is held
        while (!holding) begin
            stepCycle(1'b0);
        end
        repeat (StallCycles) begin
            stepCycle(1'b0);
        end
        while (wordIdx < NumCases * ChunksPerBlock) begin
            rnd = $random(seedVar);
            stepCycle(rnd[0]);
        end

        // A second reset must bring back the words of counter 0
        @(posedge Clock);
        #1;
        applyReset();
        while (wordIdx < 2 * ChunksPerBlock) begin
            stepCycle(1'b1);
        end

        $display("Checked %0d words and %0d blocks, %0d errors",
                 wordsChecked, blocksChecked, errorCount);
        if (errorCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WatchdogCycles * ClockPeriod);
        $display("timeout: output stream stalled at word %0d", wordIdx);
        $display("Checked %0d words and %0d blocks, %0d errors",
                 wordsChecked, blocksChecked, errorCount);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== prngCases.txt ====
// One 128-bit hex block per line, byte 0 first (most significant)
// Rows: generator key, check key, check plaintext, check ciphertext, counters 0 to 11
d840e1a8dccae7ecd91f61487af2cb73
000102030405060708090a0b0c0d0e0f
00112233445566778899aabbccddeeff
69c4e0d86a7b0430d8cdb78070b4c55a
00000000000000000000000000000000
00000000000000000000000000000001
00000000000000000000000000000002
00000000000000000000000000000003
00000000000000000000000000000004
00000000000000000000000000000005
00000000000000000000000000000006
00000000000000000000000000000007
00000000000000000000000000000008
00000000000000000000000000000009
0000000000000000000000000000000a
0000000000000000000000000000000b

// ==== filelist.f ====
aesPkg.sv
prngPkg.sv
aesCore.sv
blockBuffer.sv
widthFunnel.sv
prng.sv
tbPrng.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# Build the PRNG testbench with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tbPrng -f filelist.f -o simPrng \
    || { echo "Verilator build failed"; exit 1; }

simOutput="$(./obj_dir/simPrng)"
echo "${simOutput}"
grep -qx "Simulation passed" <<< "${simOutput}" && exit 0 || exit 1
